// File: src/synth_pkg.sv
package synth_pkg;

    // default voice count and index width for the top level
    localparam int voices_max = 8;
    localparam int v_width    = 3;

    typedef logic [7:0] midi_byte_t;

    typedef logic [v_width-1:0] voice_idx_t;

    // what the note stack decided for a voice
    typedef enum logic [1:0] {
        ev_on      = 2'd0,
        ev_off     = 2'd1,
        ev_all_off = 2'd2
    } ev_kind_t;

    // vel is the release velocity on an off event, zero when stolen
    typedef struct packed {
        ev_kind_t   kind;
        voice_idx_t slot;
        midi_byte_t key;
        midi_byte_t vel;
    } voice_event_t;

    // empty key slot marker
    localparam midi_byte_t key_none = 8'hff;

    // controller number for all notes off
    localparam midi_byte_t cc_all_notes_off = 8'd123;

endpackage

// File: src/voice_event_if.sv
`timescale 1ns/100ps

interface voice_event_if #(
    parameter type payload_t = logic [7:0]
);

    logic     push;
    payload_t wr_data;
    logic     pop;
    payload_t rd_data;
    logic     empty;

    // note stack side
    modport producer (output push, output wr_data);

    modport buffer (input push, input wr_data, input pop, output rd_data, output empty);

    // gate bank side, pops the head
    modport consumer (output pop, input rd_data, input empty);

endinterface

// File: src/midi_byte_decoder.sv
`timescale 1ns/100ps

module midi_byte_decoder
    import synth_pkg::*;
(
    input  logic       reg_clk,
    input  logic       reset_reg_N,
    input  logic       midi_valid,
    input  midi_byte_t midi_byte,
    output logic       trig,
    output logic       is_note_byte,
    output logic       is_velocity,
    output logic       is_note_on,
    output logic       is_note_off,
    output logic       is_ctrl,
    output midi_byte_t data_byte
);

    typedef enum logic [1:0] {st_none, st_note_on, st_note_off, st_ctrl} status_t;

    status_t status;
    logic    phase;
    logic    cc_hit;
    logic    known;

    // data bytes under any other status are dropped
    assign known = (status != st_none);

    always_ff @(posedge reg_clk) begin
        if (!reset_reg_N) begin
            status       <= st_none;
            phase        <= 1'b0;
            cc_hit       <= 1'b0;
            trig         <= 1'b0;
            is_note_byte <= 1'b0;
            is_velocity  <= 1'b0;
            is_note_on   <= 1'b0;
            is_note_off  <= 1'b0;
            is_ctrl      <= 1'b0;
        end else begin
            trig <= 1'b0;
            if (midi_valid) begin
                if (midi_byte[7]) begin
                    // new running status, channel nibble ignored
                    phase <= 1'b0;
                    case (midi_byte[7:4])
                        4'h9:    status <= st_note_on;
                        4'h8:    status <= st_note_off;
                        4'hb:    status <= st_ctrl;
                        default: status <= st_none;
                    endcase
                end else if (known) begin
                    trig         <= 1'b1;
                    phase        <= ~phase;
                    is_note_byte <= ~phase;
                    is_velocity  <= phase;
                    is_note_on   <= (status == st_note_on);
                    is_note_off  <= (status == st_note_off);
                    // only all notes off is passed on as a controller
                    is_ctrl      <= (status == st_ctrl) &&
                                    (phase ? cc_hit : (midi_byte == cc_all_notes_off));
                    if (!phase) begin
                        cc_hit <= (midi_byte == cc_all_notes_off);
                    end
                    data_byte    <= midi_byte;
                end
            end
        end
    end

endmodule

// File: src/note_stack.sv
`timescale 1ns/100ps

module note_stack
    import synth_pkg::*;
#(
    parameter int VOICES  = voices_max,
    parameter int V_WIDTH = v_width
) (
    input  logic                reg_clk,
    input  logic                reset_reg_N,
    input  logic                trig,
    input  logic                is_note_byte,
    input  logic                is_velocity,
    input  logic                is_note_on,
    input  logic                is_note_off,
    input  logic                is_ctrl,
    input  midi_byte_t          data_byte,
    input  logic [VOICES-1:0]   voice_free,
    voice_event_if.producer     ev,
    output logic [V_WIDTH:0]    active_keys
);

    localparam logic [V_WIDTH:0] all_busy = (V_WIDTH+1)'(VOICES);

    midi_byte_t         key_val [VOICES];
    // age[0] is the oldest held voice, entries below active_keys are valid
    logic [V_WIDTH-1:0] age [VOICES];
    midi_byte_t         cur_note;
    logic [V_WIDTH-1:0] target;
    logic               note_msg;
    logic               hit;
    logic [V_WIDTH-1:0] hit_slot;
    logic [V_WIDTH-1:0] hit_pos;
    logic [V_WIDTH-1:0] free_slot;

    assign note_msg = is_note_on | is_note_off;

    always_comb begin
        hit       = 1'b0;
        hit_slot  = '0;
        hit_pos   = '0;
        free_slot = '0;
        // lowest voice holding the latched key
        for (int i = VOICES - 1; i >= 0; i--) begin
            if (key_val[i] != key_none && key_val[i] == cur_note) begin
                hit      = 1'b1;
                hit_slot = V_WIDTH'(i);
            end
        end
        // where that voice sits in the age order
        for (int p = VOICES - 1; p >= 0; p--) begin
            if (p < int'(active_keys) && age[p] == hit_slot) begin
                hit_pos = V_WIDTH'(p);
            end
        end
        for (int i = VOICES - 1; i >= 0; i--) begin
            if (voice_free[i]) begin
                free_slot = V_WIDTH'(i);
            end
        end
    end

    always_ff @(posedge reg_clk) begin
        if (!reset_reg_N) begin
            active_keys <= '0;
            cur_note    <= key_none;
            target      <= '0;
            ev.push     <= 1'b0;
            for (int i = 0; i < VOICES; i++) begin
                key_val[i] <= key_none;
                age[i]     <= '0;
            end
        end else begin
            ev.push <= 1'b0;
            if (trig) begin
                if (is_ctrl) begin
                    if (is_note_byte) begin
                        for (int i = 0; i < VOICES; i++) begin
                            key_val[i] <= key_none;
                        end
                        active_keys <= '0;
                        ev.push     <= 1'b1;
                        ev.wr_data  <= '{kind: ev_all_off, slot: '0, key: key_none, vel: 8'd0};
                    end
                end else if (is_note_byte && note_msg) begin
                    cur_note <= data_byte;
                    if (is_note_on) begin
                        if (active_keys == all_busy) begin
                            // steal the oldest voice, its slot takes the new note
                            key_val[age[0]] <= key_none;
                            for (int q = 0; q < VOICES - 1; q++) begin
                                age[q] <= age[q+1];
                            end
                            active_keys <= active_keys - 1'b1;
                            target      <= age[0];
                            ev.push     <= 1'b1;
                            ev.wr_data  <= '{kind: ev_off, slot: voice_idx_t'(age[0]),
                                             key: key_val[age[0]], vel: 8'd0};
                        end else begin
                            target <= free_slot;
                        end
                    end
                end else if (is_velocity && is_note_on && data_byte != 8'd0) begin
                    key_val[target]                 <= cur_note;
                    age[active_keys[V_WIDTH-1:0]]   <= target;
                    active_keys                     <= active_keys + 1'b1;
                    ev.push                         <= 1'b1;
                    ev.wr_data <= '{kind: ev_on, slot: voice_idx_t'(target),
                                    key: cur_note, vel: data_byte};
                end else if (is_velocity && note_msg && hit) begin
                    // note off, or note on with velocity zero
                    key_val[hit_slot] <= key_none;
                    for (int q = 0; q < VOICES - 1; q++) begin
                        if (q >= int'(hit_pos)) begin
                            age[q] <= age[q+1];
                        end
                    end
                    active_keys <= active_keys - 1'b1;
                    ev.push     <= 1'b1;
                    ev.wr_data  <= '{kind: ev_off, slot: voice_idx_t'(hit_slot),
                                     key: cur_note, vel: data_byte};
                end
            end
        end
    end

endmodule

// File: src/voice_event_fifo.sv
`timescale 1ns/100ps

module voice_event_fifo #(
    parameter int  DEPTH     = 4,
    parameter type payload_t = logic [7:0]
) (
    input  logic          reg_clk,
    input  logic          reset_reg_N,
    voice_event_if.buffer ev
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          full;
    logic          do_wr;
    logic          do_rd;

    assign full       = (count == CW'(DEPTH));
    assign ev.empty   = (count == '0);
    assign ev.rd_data = mem[rd_ptr];
    // a push while full is lost
    assign do_wr      = ev.push && !full;
    assign do_rd      = ev.pop && !ev.empty;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge reg_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= ev.wr_data;
        end
    end

    always_ff @(posedge reg_clk) begin
        if (!reset_reg_N) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: src/voice_gate_bank.sv
`timescale 1ns/100ps

module voice_gate_bank
    import synth_pkg::*;
#(
    parameter int VOICES  = voices_max,
    parameter int V_WIDTH = v_width
) (
    input  logic               reg_clk,
    input  logic               reset_reg_N,
    voice_event_if.consumer    ev,
    output logic [VOICES-1:0]  voice_gate,
    output logic [VOICES-1:0]  voice_free,
    output logic               ev_strobe,
    output ev_kind_t           ev_kind,
    output logic [V_WIDTH-1:0] ev_slot,
    output midi_byte_t         ev_key,
    output midi_byte_t         ev_vel
);

    midi_byte_t   key_q [VOICES];
    voice_event_t head;

    assign head       = ev.rd_data;
    // drain one event per cycle
    assign ev.pop     = !ev.empty;
    assign voice_free = ~voice_gate;

    always_ff @(posedge reg_clk) begin
        if (!reset_reg_N) begin
            voice_gate <= '0;
            ev_strobe  <= 1'b0;
        end else begin
            ev_strobe <= ev.pop;
            if (ev.pop) begin
                case (head.kind)
                    ev_on: begin
                        voice_gate[head.slot] <= 1'b1;
                        key_q[head.slot]      <= head.key;
                    end
                    ev_off:     voice_gate[head.slot] <= 1'b0;
                    ev_all_off: voice_gate <= '0;
                    default:    voice_gate <= voice_gate;
                endcase
                ev_kind <= head.kind;
                ev_slot <= V_WIDTH'(head.slot);
                // off events report the key the voice was holding
                ev_key  <= (head.kind == ev_off) ? key_q[head.slot] : head.key;
                ev_vel  <= head.vel;
            end
        end
    end

endmodule

// File: src/midi_voice_top.sv
`timescale 1ns/100ps

module midi_voice_top
    import synth_pkg::*;
#(
    parameter int VOICES  = voices_max,
    parameter int V_WIDTH = v_width,
    parameter int DEPTH   = 4
) (
    input  logic               reg_clk,
    input  logic               reset_reg_N,
    input  logic               midi_valid,
    input  midi_byte_t         midi_byte,
    output logic [VOICES-1:0]  voice_gate,
    output logic [V_WIDTH:0]   active_keys,
    output logic               ev_strobe,
    output ev_kind_t           ev_kind,
    output logic [V_WIDTH-1:0] ev_slot,
    output midi_byte_t         ev_key,
    output midi_byte_t         ev_vel
);

    logic              trig;
    logic              is_note_byte;
    logic              is_velocity;
    logic              is_note_on;
    logic              is_note_off;
    logic              is_ctrl;
    midi_byte_t        data_byte;
    logic [VOICES-1:0] voice_free;

    voice_event_if #(.payload_t(voice_event_t)) ev_if ();

    midi_byte_decoder i_decoder (
        .reg_clk, .reset_reg_N, .midi_valid, .midi_byte, .trig, .is_note_byte,
        .is_velocity, .is_note_on, .is_note_off, .is_ctrl, .data_byte
    );

    note_stack #(.VOICES(VOICES), .V_WIDTH(V_WIDTH)) i_note_stack (
        .reg_clk, .reset_reg_N, .trig, .is_note_byte, .is_velocity, .is_note_on,
        .is_note_off, .is_ctrl, .data_byte, .voice_free, .ev(ev_if.producer), .active_keys
    );

    voice_event_fifo #(.DEPTH(DEPTH), .payload_t(voice_event_t)) i_event_fifo (
        .reg_clk, .reset_reg_N, .ev(ev_if.buffer)
    );

    voice_gate_bank #(.VOICES(VOICES), .V_WIDTH(V_WIDTH)) i_gate_bank (
        .reg_clk, .reset_reg_N, .ev(ev_if.consumer), .voice_gate, .voice_free,
        .ev_strobe, .ev_kind, .ev_slot, .ev_key, .ev_vel
    );

endmodule

// File: tests/midi_voice_properties.sv
`timescale 1ns/100ps

module midi_voice_properties
    import synth_pkg::*;
#(
    parameter int VOICES     = voices_max,
    parameter bit GATE_CHECK = 1'b0
) (
    input logic              reg_clk,
    input logic              reset_reg_N,
    input logic              push,
    input logic              full,
    input logic              pop,
    input logic              empty,
    input logic [VOICES-1:0] voice_gate
);

    if (GATE_CHECK) begin : g_gate
        // gates only move when an event is applied
        a_gate_hold: assert property (@(posedge reg_clk) disable iff (!reset_reg_N)
            !pop |=> $stable(voice_gate)) else $error("voice_gate changed without an event");
    end else begin : g_fifo
        // no back-pressure on the event FIFO
        a_no_push_full: assert property (@(posedge reg_clk) disable iff (!reset_reg_N)
            !(push && full)) else $error("event pushed into a full FIFO");

        // a pushed event is waiting at the head one cycle later
        a_push_seen: assert property (@(posedge reg_clk) disable iff (!reset_reg_N)
            push |=> !empty) else $error("FIFO still empty after a push");
    end

endmodule

// File: tests/tb_midi_voice.sv
`timescale 1ns/100ps

module tb_midi_voice
    import synth_pkg::*;
();

    localparam int VOICES  = voices_max;
    localparam int V_WIDTH = v_width;
    localparam int SPACING = 6;
    localparam int TIMEOUT = 20;

    // running status as seen by the model
    localparam int st_none = 0;
    localparam int st_on   = 1;
    localparam int st_off  = 2;
    localparam int st_ctrl = 3;

    logic               reg_clk;
    logic               reset_reg_N;
    logic               midi_valid;
    midi_byte_t         midi_byte;
    logic [VOICES-1:0]  voice_gate;
    logic [V_WIDTH:0]   active_keys;
    logic               ev_strobe;
    ev_kind_t           ev_kind;
    logic [V_WIDTH-1:0] ev_slot;
    midi_byte_t         ev_key;
    midi_byte_t         ev_vel;

    // model state, m_age holds voices oldest first
    midi_byte_t   m_key [VOICES];
    int           m_age [$];
    int           m_status;
    logic         m_phase;
    midi_byte_t   m_note;
    int           m_target;
    logic         exp_valid;
    voice_event_t exp_ev;

    midi_voice_top #(.VOICES(VOICES), .V_WIDTH(V_WIDTH), .DEPTH(4)) i_midi_voice_top (
        .reg_clk, .reset_reg_N, .midi_valid, .midi_byte, .voice_gate, .active_keys,
        .ev_strobe, .ev_kind, .ev_slot, .ev_key, .ev_vel
    );

    bind voice_event_fifo midi_voice_properties i_fifo_props (
        .reg_clk, .reset_reg_N, .push(ev.push), .full, .pop(ev.pop), .empty(ev.empty),
        .voice_gate('0)
    );

    bind voice_gate_bank midi_voice_properties #(.VOICES(VOICES), .GATE_CHECK(1'b1))
        i_gate_props (
        .reg_clk, .reset_reg_N, .push(1'b0), .full(1'b0), .pop(ev.pop), .empty(ev.empty),
        .voice_gate
    );

    initial reg_clk = 1'b0;
    always #20 reg_clk = ~reg_clk;

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_event(input voice_event_t exp);
        if (ev_kind !== exp.kind) begin
            stop_run($sformatf("Fail at %0t: ev_kind expected %0d got %0d",
                               $time, exp.kind, ev_kind));
        end
        if (ev_slot !== exp.slot) begin
            stop_run($sformatf("Fail at %0t: ev_slot expected %0d got %0d",
                               $time, exp.slot, ev_slot));
        end
        if (ev_key !== exp.key) begin
            stop_run($sformatf("Fail at %0t: ev_key expected %h got %h", $time, exp.key, ev_key));
        end
        if (ev_vel !== exp.vel) begin
            stop_run($sformatf("Fail at %0t: ev_vel expected %h got %h", $time, exp.vel, ev_vel));
        end
    endtask

    task automatic check_gates(input logic [VOICES-1:0] exp);
        if (voice_gate !== exp) begin
            stop_run($sformatf("Fail at %0t: voice_gate expected %b got %b",
                               $time, exp, voice_gate));
        end
    endtask

    task automatic check_count(input logic [V_WIDTH:0] exp);
        if (active_keys !== exp) begin
            stop_run($sformatf("Fail at %0t: active_keys expected %0d got %0d",
                               $time, exp, active_keys));
        end
    endtask

    task automatic model_reset();
        foreach (m_key[i]) begin
            m_key[i] = key_none;
        end
        m_age.delete();
        m_status = st_none;
        m_phase  = 1'b0;
        m_note   = key_none;
        m_target = 0;
    endtask

    function automatic logic [VOICES-1:0] model_gates();
        logic [VOICES-1:0] g;
        for (int i = 0; i < VOICES; i++) begin
            g[i] = (m_key[i] != key_none);
        end
        return g;
    endfunction

    // lowest voice holding the latched note is released
    task automatic model_release(input midi_byte_t vel);
        int slot;
        int pos;
        slot = -1;
        pos  = -1;
        for (int i = VOICES - 1; i >= 0; i--) begin
            if (m_key[i] == m_note) begin
                slot = i;
            end
        end
        if (slot >= 0) begin
            for (int p = m_age.size() - 1; p >= 0; p--) begin
                if (m_age[p] == slot) begin
                    pos = p;
                end
            end
            m_age.delete(pos);
            m_key[slot] = key_none;
            exp_valid   = 1'b1;
            exp_ev      = '{kind: ev_off, slot: voice_idx_t'(slot), key: m_note, vel: vel};
        end
    endtask

    task automatic model_byte(input midi_byte_t b);
        int slot;
        exp_valid = 1'b0;
        if (b[7]) begin
            m_phase = 1'b0;
            case (b[7:4])
                4'h9:    m_status = st_on;
                4'h8:    m_status = st_off;
                4'hb:    m_status = st_ctrl;
                default: m_status = st_none;
            endcase
        end else if (m_status != st_none) begin
            if (!m_phase && m_status == st_ctrl) begin
                if (b == cc_all_notes_off) begin
                    model_reset_voices();
                end
            end else if (!m_phase) begin
                m_note = b;
                if (m_status == st_on && m_age.size() == VOICES) begin
                    // oldest voice is stolen for the new note
                    slot        = m_age.pop_front();
                    exp_valid   = 1'b1;
                    exp_ev      = '{kind: ev_off, slot: voice_idx_t'(slot),
                                    key: m_key[slot], vel: 8'd0};
                    m_key[slot] = key_none;
                    m_target    = slot;
                end else if (m_status == st_on) begin
                    m_target = -1;
                    for (int i = VOICES - 1; i >= 0; i--) begin
                        if (m_key[i] == key_none) begin
                            m_target = i;
                        end
                    end
                end
            end else if (m_status == st_on && b != 8'd0) begin
                m_key[m_target] = m_note;
                m_age.push_back(m_target);
                exp_valid = 1'b1;
                exp_ev    = '{kind: ev_on, slot: voice_idx_t'(m_target), key: m_note, vel: b};
            end else if (m_status != st_ctrl) begin
                model_release(b);
            end
            m_phase = !m_phase;
        end
    endtask

    task automatic model_reset_voices();
        foreach (m_key[i]) begin
            m_key[i] = key_none;
        end
        m_age.delete();
        exp_valid = 1'b1;
        exp_ev    = '{kind: ev_all_off, slot: '0, key: key_none, vel: 8'd0};
    endtask

    // called 2 ns after an edge, returns six cycles later
    task automatic send_byte(input midi_byte_t b);
        int n;
        midi_valid = 1'b1;
        midi_byte  = b;
        @(posedge reg_clk);
        #2;
        midi_valid = 1'b0;
        model_byte(b);
        n = 1;
        if (exp_valid) begin
            while (ev_strobe !== 1'b1) begin
                if (n > TIMEOUT) begin
                    stop_run("no voice event arrived within 20 cycles of a MIDI byte");
                end
                @(posedge reg_clk);
                #2;
                n++;
            end
            check_event(exp_ev);
        end
        while (n < SPACING) begin
            @(posedge reg_clk);
            #2;
            n++;
            if (ev_strobe !== 1'b0) begin
                stop_run("an unexpected voice event appeared after a MIDI byte");
            end
        end
        check_gates(model_gates());
        check_count((V_WIDTH+1)'(m_age.size()));
    endtask

    // status byte is skipped at random when running status covers it
    task automatic send_status(input int st, input logic [3:0] hi);
        if (m_status != st || $urandom_range(0, 2) == 0) begin
            send_byte({hi, 4'($urandom_range(0, 15))});
        end
    endtask

    task automatic random_message();
        int         r;
        int         held;
        midi_byte_t key;
        r   = $urandom_range(0, 99);
        key = 8'($urandom_range(48, 59));
        if (r < 45) begin
            send_status(st_on, 4'h9);
            send_byte(key);
            send_byte(($urandom_range(0, 5) == 0) ? 8'd0 : 8'($urandom_range(1, 127)));
        end else if (r < 70) begin
            // held key about half the time
            held = $urandom_range(0, VOICES - 1);
            if ($urandom_range(0, 1) == 0 && m_key[held] != key_none) begin
                key = m_key[held];
            end
            send_status(st_off, 4'h8);
            send_byte(key);
            send_byte(8'($urandom_range(0, 127)));
        end else if (r < 74) begin
            send_status(st_ctrl, 4'hb);
            send_byte(cc_all_notes_off);
            send_byte(8'd0);
        end else if (r < 88) begin
            send_status(st_ctrl, 4'hb);
            send_byte(8'($urandom_range(0, 122)));
            send_byte(8'($urandom_range(0, 127)));
        end else begin
            // aftertouch status, its data bytes are ignored
            send_byte({4'ha, 4'($urandom_range(0, 15))});
            send_byte(key);
            send_byte(8'($urandom_range(0, 127)));
        end
    endtask

    initial begin
        void'($urandom(32'h4ab));
        reset_reg_N = 1'b0;
        midi_valid  = 1'b0;
        midi_byte   = 8'h00;
        model_reset();
        repeat (3) @(posedge reg_clk);
        #2;
        reset_reg_N = 1'b1;
        for (int i = 0; i < SPACING; i++) begin
            @(posedge reg_clk);
            #2;
            if (ev_strobe !== 1'b0) begin
                stop_run("a voice event appeared after reset with no stimulus");
            end
        end
        check_gates('0);
        check_count('0);
        // fill every voice, then two more notes force stealing
        for (int i = 0; i < VOICES + 2; i++) begin
            send_status(st_on, 4'h9);
            send_byte(8'(60 + i));
            send_byte(8'd100);
        end
        for (int i = 0; i < 400; i++) begin
            random_message();
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

// File: flist.f
src/synth_pkg.sv
src/voice_event_if.sv
src/midi_byte_decoder.sv
src/note_stack.sv
src/voice_event_fifo.sv
src/voice_gate_bank.sv
src/midi_voice_top.sv
tests/midi_voice_properties.sv
tests/tb_midi_voice.sv

// File: Makefile
TOP = tb_midi_voice

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f flist.f -o sim_$(TOP)
	out=$$(./obj_dir/sim_$(TOP)); echo "$$out"; echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir

.PHONY: sim clean
